/* neuron_node.f */
+incdir+test
hw/float_pkg.sv
hw/node_pkg.sv
hw/float_mult.sv
hw/float_adder.sv
hw/node_mult_stage.sv
hw/node_sum_tree.sv
hw/neuron_node.sv
test/neuron_node_assert.sv
test/neuron_node_tb.sv

/* test/float_ref.svh */
`ifndef FLOAT_REF_SVH
`define FLOAT_REF_SVH

// ############################################################
// Model of the truncating float rules
// ############################################################

function automatic float_t ref_mult(input float_t x, input float_t y);
	logic [47:0] mx;
	logic [47:0] my;
	logic [47:0] prod;
	logic [23:0] m;
	int e;
	if (x[30:23] == 8'd0 || y[30:23] == 8'd0)
		return 32'd0;                     // Zero or flushed operand.
	mx = {24'd0, 1'b1, x[22:0]};
	my = {24'd0, 1'b1, y[22:0]};
	prod = mx * my;
	e = int'(x[30:23]) + int'(y[30:23]) - EXP_BIAS;
	if (prod[47])
	begin
		m = prod[47:24];
		e = e + 1;
	end
	else
		m = prod[46:23];
	if (e <= 0)
		return 32'd0;
	if (e > EXP_MAX_FINITE)
		return {x[31] ^ y[31], FLOAT_MAX_MAG[30:0]};
	return {x[31] ^ y[31], 8'(e), m[22:0]};
endfunction

function automatic float_t ref_add(input float_t a, input float_t b);
	float_t hi;
	float_t lo;
	logic [24:0] m;
	logic [24:0] m_lo;
	int d;
	int e;
	if (a[30:23] == 8'd0)
		return b;
	if (b[30:23] == 8'd0)
		return a;
	hi = (a[30:0] >= b[30:0]) ? a : b;   // Larger magnitude first.
	lo = (a[30:0] >= b[30:0]) ? b : a;
	e = int'(hi[30:23]);
	d = e - int'(lo[30:23]);
	m_lo = (d >= 24) ? 25'd0 : ({2'b01, lo[22:0]} >> d);
	if (hi[31] == lo[31])
		m = {2'b01, hi[22:0]} + m_lo;
	else
		m = {2'b01, hi[22:0]} - m_lo;
	if (m == 25'd0)
		return 32'd0;
	if (m[24])
	begin
		m = m >> 1;
		e = e + 1;
	end
	else
	begin
		while (!m[23])
		begin
			m = m << 1;
			e = e - 1;
		end
	end
	if (e <= 0)
		return 32'd0;
	if (e > EXP_MAX_FINITE)
		return {hi[31], FLOAT_MAX_MAG[30:0]};
	return {hi[31], 8'(e), m[22:0]};
endfunction

// Weights, balanced tree and ReLU.
function automatic float_t ref_node(input float_t x [NUM_INPUTS]);
	float_t p [NUM_INPUTS];
	float_t s [NUM_INPUTS/2];
	float_t t0;
	float_t t1;
	float_t t2;
	float_t total;
	for (int i = 0; i < NUM_INPUTS; i++)
		p[i] = ref_mult(x[i], NODE_WEIGHTS[i]);
	for (int i = 0; i < NUM_INPUTS/2; i++)
		s[i] = ref_add(p[2*i], p[2*i+1]);
	t0 = ref_add(s[0], s[1]);
	t1 = ref_add(s[2], s[3]);
	t2 = ref_add(t0, t1);
	total = ref_add(t2, s[4]);
	return total[31] ? 32'd0 : total;
endfunction

`endif

/* test/neuron_node_tb.sv */
`timescale 1ns/1ns

module neuron_node_tb import float_pkg::*, node_pkg::*; ();

	`include "float_ref.svh"

	logic clk;
	logic rst_n;
	logic in_valid;
	float_t act [NUM_INPUTS];
	logic out_valid;
	float_t n1;

	float_t exp_q [$];
	int issue_q [$];
	int cyc;
	int errors;
	int checks;
	float_t expected;
	float_t last_n1;
	int issued;
	logic [31:0] rng_state;

	neuron_node u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.a0(act[0]),
		.a1(act[1]),
		.a2(act[2]),
		.a3(act[3]),
		.a4(act[4]),
		.a5(act[5]),
		.a6(act[6]),
		.a7(act[7]),
		.a8(act[8]),
		.a9(act[9]),
		.out_valid(out_valid),
		.n1(n1)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk)
		cyc <= cyc + 1;

	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// Random sign and fraction, exponent in [exp_lo, exp_lo+exp_span).
	function automatic float_t rand_float(input int exp_lo, input int exp_span);
		logic [31:0] r;
		int e;
		r = next_rand();
		e = exp_lo + int'(next_rand() % exp_span);
		return {r[31], 8'(e), r[22:0]};
	endfunction

	// ############################################################
	// Stimulus
	// ############################################################
	task automatic drive_set(input float_t v [NUM_INPUTS]);
		@(posedge clk);
		#1;
		in_valid = 1'b1;
		act = v;
		exp_q.push_back(ref_node(v));
		issue_q.push_back(cyc);           // Cycle of the drive edge.
	endtask

	task automatic drive_idle(input int n);
		repeat (n)
		begin
			@(posedge clk);
			#1;
			in_valid = 1'b0;
		end
	endtask

	task automatic drive_fill(input float_t value);
		float_t v [NUM_INPUTS];
		for (int i = 0; i < NUM_INPUTS; i++)
			v[i] = value;
		drive_set(v);
	endtask

	task automatic drive_random(input int exp_lo, input int exp_span);
		float_t v [NUM_INPUTS];
		for (int i = 0; i < NUM_INPUTS; i++)
			v[i] = rand_float(exp_lo, exp_span);
		drive_set(v);
	endtask

	task automatic wait_drain(input int limit);
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < limit)
		begin
			@(negedge clk);
			n++;
		end
		if (exp_q.size() != 0)
		begin
			$display("Timeout: results still pending after %0d cycles", limit);
			errors++;
		end
	endtask

	// ############################################################
	// Checker
	// ############################################################
	always @(negedge clk)
	begin
		if (!rst_n)
		begin
			if (out_valid !== 1'b0)
			begin
				$display("out_valid is not low during reset");
				errors++;
			end
		end
		else if (out_valid)
		begin
			if (exp_q.size() == 0)
			begin
				$display("out_valid went high with no result pending at cycle %0d", cyc);
				errors++;
			end
			else
			begin
				expected = exp_q.pop_front();
				issued = issue_q.pop_front();
				checks++;
				if (n1 !== expected)
				begin
					$display("[FAIL] n1 got 0x%08h expected 0x%08h", n1, expected);
					errors++;
				end
				if (cyc - issued != NODE_LATENCY)
				begin
					$display("Result came %0d cycles after its input, not %0d",
						cyc - issued, NODE_LATENCY);
					errors++;
				end
			end
			last_n1 = n1;
		end
		else if (n1 !== last_n1)
		begin
			$display("[FAIL] n1 got 0x%08h expected 0x%08h while idle", n1, last_n1);
			errors++;
		end
	end

	initial
	begin
		rng_state = 32'heaa6;
		cyc = 0;
		errors = 0;
		checks = 0;
		last_n1 = '0;
		in_valid = 1'b0;
		for (int i = 0; i < NUM_INPUTS; i++)
			act[i] = '0;
		rst_n = 1'b1;
		#1 rst_n = 1'b0;
		repeat (5) @(posedge clk);
		#1 rst_n = 1'b1;

		drive_idle(10);                   // Idle, nothing may come out.

		// Directed sets.
		drive_fill(32'h0000_0000);
		drive_fill(32'h3f80_0000);
		drive_set('{32'h3f80_0000, 0, 0, 32'h3f80_0000, 0,
			32'h3f80_0000, 0, 32'h3f80_0000, 0, 0});  // Negative weights only.
		drive_idle(1);
		wait_drain(20);

		// Isolated set for latency.
		drive_idle(10);
		drive_random(124, 6);
		drive_idle(10);
		wait_drain(20);

		for (int i = 0; i < 200; i++)
			drive_random(123, 8);
		drive_idle(1);
		wait_drain(20);

		for (int i = 0; i < 100; i++)
		begin
			drive_random(123, 8);
			drive_idle(int'(next_rand() % 4));
		end
		drive_idle(1);
		wait_drain(20);

		// Range ends, clamp and flush.
		drive_fill(FLOAT_MAX_MAG);
		for (int i = 0; i < 20; i++)
			drive_random(250, 5);
		for (int i = 0; i < 20; i++)
			drive_random(1, 4);
		drive_idle(1);
		wait_drain(20);

		drive_idle(10);
		if (exp_q.size() != 0)
		begin
			$display("%0d expected results never came out", exp_q.size());
			errors++;
		end
		errors += u_dut.u_assert.fail_count;
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* test/neuron_node_assert.sv */
`timescale 1ns/1ns

module neuron_node_assert import float_pkg::*, node_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input logic out_valid,
	input float_t n1
);

	int fail_count = 0;

	// One result per input set, fixed delay.
	assert property (@(posedge clk) disable iff (!rst_n)
		$past(in_valid, NODE_LATENCY) |-> out_valid)
		else
		begin
			$error("out_valid missing %0d cycles after in_valid", NODE_LATENCY);
			fail_count++;
		end

	assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> $past(in_valid, NODE_LATENCY))
		else
		begin
			$error("out_valid without in_valid %0d cycles before", NODE_LATENCY);
			fail_count++;
		end

	assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> !n1[31])
		else
		begin
			$error("n1 negative with out_valid high");
			fail_count++;
		end

	assert property (@(posedge clk) !rst_n |-> !out_valid)
		else
		begin
			$error("out_valid high during reset");
			fail_count++;
		end

endmodule

bind neuron_node neuron_node_assert u_assert (
	.clk(clk),
	.rst_n(rst_n),
	.in_valid(in_valid),
	.out_valid(out_valid),
	.n1(n1)
);

/* hw/neuron_node.sv */
`timescale 1ns/1ns

module neuron_node import float_pkg::*, node_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input float_t a0,
	input float_t a1,
	input float_t a2,
	input float_t a3,
	input float_t a4,
	input float_t a5,
	input float_t a6,
	input float_t a7,
	input float_t a8,
	input float_t a9,
	output logic out_valid,
	output float_t n1
);

	logic prod_valid;
	float_t p0;
	float_t p1;
	float_t p2;
	float_t p3;
	float_t p4;
	float_t p5;
	float_t p6;
	float_t p7;
	float_t p8;
	float_t p9;
	logic sum_valid;
	float_t sum;

	node_mult_stage u_mult (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.a0(a0),
		.a1(a1),
		.a2(a2),
		.a3(a3),
		.a4(a4),
		.a5(a5),
		.a6(a6),
		.a7(a7),
		.a8(a8),
		.a9(a9),
		.prod_valid(prod_valid),
		.p0(p0),
		.p1(p1),
		.p2(p2),
		.p3(p3),
		.p4(p4),
		.p5(p5),
		.p6(p6),
		.p7(p7),
		.p8(p8),
		.p9(p9)
	);

	node_sum_tree u_tree (
		.clk(clk),
		.rst_n(rst_n),
		.prod_valid(prod_valid),
		.p0(p0),
		.p1(p1),
		.p2(p2),
		.p3(p3),
		.p4(p4),
		.p5(p5),
		.p6(p6),
		.p7(p7),
		.p8(p8),
		.p9(p9),
		.sum_valid(sum_valid),
		.sum(sum)
	);

	// ReLU output register.
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			out_valid <= 1'b0;
			n1 <= '0;
		end
		else
		begin
			out_valid <= sum_valid;
			if (sum_valid)
				n1 <= sum[31] ? float_t'(0) : sum;  // Negative clamps to zero.
		end
	end

endmodule

/* hw/node_sum_tree.sv */
`timescale 1ns/1ns

module node_sum_tree import float_pkg::*, node_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic prod_valid,
	input float_t p0,
	input float_t p1,
	input float_t p2,
	input float_t p3,
	input float_t p4,
	input float_t p5,
	input float_t p6,
	input float_t p7,
	input float_t p8,
	input float_t p9,
	output logic sum_valid,
	output float_t sum
);

	float_t p_vec [NUM_INPUTS];
	float_t add1 [NUM_INPUTS/2];
	float_t s1 [NUM_INPUTS/2];
	float_t add2 [2];
	float_t s2 [2];
	float_t pass2;
	float_t add3;
	float_t s3;
	float_t pass3;
	float_t add4;
	logic v1;
	logic v2;
	logic v3;

	assign p_vec = '{p0, p1, p2, p3, p4, p5, p6, p7, p8, p9};

	// ############################################################
	// Adders, pairing (0,1) (2,3) (4,5) (6,7) (8,9)
	// ############################################################
	genvar i;
	generate
		for (i = 0; i < NUM_INPUTS/2; i++)
		begin : g_lvl1
			float_adder u_add (
				.a(p_vec[2*i]),
				.b(p_vec[2*i+1]),
				.sum(add1[i])
			);
		end
	endgenerate

	float_adder u_add2_0 (.a(s1[0]), .b(s1[1]), .sum(add2[0]));
	float_adder u_add2_1 (.a(s1[2]), .b(s1[3]), .sum(add2[1]));
	float_adder u_add3 (.a(s2[0]), .b(s2[1]), .sum(add3));
	float_adder u_add4 (.a(s3), .b(pass3), .sum(add4));

	// ############################################################
	// Level registers, each with its own valid
	// ############################################################
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			v1 <= 1'b0;
			v2 <= 1'b0;
			v3 <= 1'b0;
			sum_valid <= 1'b0;
			s1 <= '{default: '0};
			s2 <= '{default: '0};
			pass2 <= '0;
			s3 <= '0;
			pass3 <= '0;
			sum <= '0;
		end
		else
		begin
			v1 <= prod_valid;
			v2 <= v1;
			v3 <= v2;
			sum_valid <= v3;
			if (prod_valid)
				s1 <= add1;
			if (v1)
			begin
				s2 <= add2;
				pass2 <= s1[4];               // s4 rides along.
			end
			if (v2)
			begin
				s3 <= add3;
				pass3 <= pass2;
			end
			if (v3)
				sum <= add4;
		end
	end

endmodule

/* hw/node_mult_stage.sv */
`timescale 1ns/1ns

module node_mult_stage import float_pkg::*, node_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input float_t a0,
	input float_t a1,
	input float_t a2,
	input float_t a3,
	input float_t a4,
	input float_t a5,
	input float_t a6,
	input float_t a7,
	input float_t a8,
	input float_t a9,
	output logic prod_valid,
	output float_t p0,
	output float_t p1,
	output float_t p2,
	output float_t p3,
	output float_t p4,
	output float_t p5,
	output float_t p6,
	output float_t p7,
	output float_t p8,
	output float_t p9
);

	float_t a_vec [NUM_INPUTS];
	float_t w_prod [NUM_INPUTS];
	float_t p_reg [NUM_INPUTS];

	assign a_vec = '{a0, a1, a2, a3, a4, a5, a6, a7, a8, a9};

	genvar i;
	generate
		for (i = 0; i < NUM_INPUTS; i++)
		begin : g_mult
			float_mult u_mult (
				.x(a_vec[i]),
				.y(NODE_WEIGHTS[i]),
				.z(w_prod[i])
			);
		end
	endgenerate

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			prod_valid <= 1'b0;
			p_reg <= '{default: '0};
		end
		else
		begin
			prod_valid <= in_valid;
			if (in_valid)
				p_reg <= w_prod;              // Load only with a new set.
		end
	end

	assign p0 = p_reg[0];
	assign p1 = p_reg[1];
	assign p2 = p_reg[2];
	assign p3 = p_reg[3];
	assign p4 = p_reg[4];
	assign p5 = p_reg[5];
	assign p6 = p_reg[6];
	assign p7 = p_reg[7];
	assign p8 = p_reg[8];
	assign p9 = p_reg[9];

endmodule

/* hw/float_adder.sv */
`timescale 1ns/1ns

module float_adder import float_pkg::*; (
	input float_t a,
	input float_t b,
	output float_t sum
);

	float_t big;
	float_t lesser;
	exp_t e_big;
	exp_t e_small;
	exp_t diff;
	mant_t m_big;
	mant_t m_small;
	mant_t m_align;
	logic [FRAC_W+1:0] m_sum;
	logic [4:0] lz;
	mant_t m_norm;
	logic signed [9:0] exp_res;
	logic sign;
	logic a_zero;
	logic b_zero;

	assign a_zero = (a[30:FRAC_W] == '0);
	assign b_zero = (b[30:FRAC_W] == '0);

	// ############################################################
	// Order by magnitude and align
	// ############################################################
	always_comb
	begin
		// Exponent over fraction compares as one unsigned field.
		if (a[30:0] >= b[30:0])
		begin
			big = a;
			lesser = b;
		end
		else
		begin
			big = b;
			lesser = a;
		end
		e_big = big[30:FRAC_W];
		e_small = lesser[30:FRAC_W];
		m_big = {1'b1, big[FRAC_W-1:0]};
		m_small = {1'b1, lesser[FRAC_W-1:0]};
		diff = e_big - e_small;
		if (diff > exp_t'(FRAC_W))
			m_align = '0;                     // Shifted out entirely.
		else
			m_align = m_small >> diff;
		sign = big[31];
	end

	// ############################################################
	// Add or subtract, then renormalize
	// ############################################################
	always_comb
	begin
		if (big[31] == lesser[31])
			m_sum = {1'b0, m_big} + {1'b0, m_align};
		else
			m_sum = {1'b0, m_big} - {1'b0, m_align};

		// Highest set bit wins.
		lz = 5'd0;
		for (int i = 0; i <= FRAC_W; i++)
		begin
			if (m_sum[i])
				lz = 5'(FRAC_W - i);
		end

		if (m_sum[FRAC_W+1])
		begin
			m_norm = m_sum[FRAC_W+1:1];       // Carry, drop the low bit.
			exp_res = $signed({2'b00, e_big}) + 10'sd1;
		end
		else
		begin
			m_norm = m_sum[FRAC_W:0] << lz;
			exp_res = $signed({2'b00, e_big}) - $signed({5'b00000, lz});
		end
	end

	always_comb
	begin
		if (a_zero)
			sum = b;
		else if (b_zero)
			sum = a;
		else if (m_sum == '0 || exp_res <= 0)
			sum = '0;
		else if (exp_res > EXP_MAX_FINITE)
			sum = {sign, FLOAT_MAX_MAG[30:0]};
		else
			sum = {sign, exp_res[7:0], m_norm[FRAC_W-1:0]};
	end

endmodule

/* hw/float_mult.sv */
`timescale 1ns/1ns

module float_mult import float_pkg::*; (
	input float_t x,
	input float_t y,
	output float_t z
);

	exp_t ex;
	exp_t ey;
	mant_t mx;
	mant_t my;
	logic [2*FRAC_W+1:0] prod;
	mant_t m_norm;
	logic signed [9:0] exp_res;
	logic sign;

	assign ex = x[30:FRAC_W];
	assign ey = y[30:FRAC_W];
	assign mx = {1'b1, x[FRAC_W-1:0]};
	assign my = {1'b1, y[FRAC_W-1:0]};
	assign sign = x[31] ^ y[31];
	assign prod = mx * my;                // Full 48-bit product.

	// Product lies in [1,4), so at most one bit of normalization.
	always_comb
	begin
		exp_res = $signed({2'b00, ex}) + $signed({2'b00, ey}) - 10'(EXP_BIAS);
		if (prod[2*FRAC_W+1])
		begin
			m_norm = prod[2*FRAC_W+1:FRAC_W+1];
			exp_res = exp_res + 10'sd1;
		end
		else
		begin
			m_norm = prod[2*FRAC_W:FRAC_W];
		end
	end

	always_comb
	begin
		if (ex == '0 || ey == '0)
			z = '0;                           // Zero or flushed operand.
		else if (exp_res <= 0)
			z = '0;                           // Underflow.
		else if (exp_res > EXP_MAX_FINITE)
			z = {sign, FLOAT_MAX_MAG[30:0]};  // Clamp.
		else
			z = {sign, exp_res[7:0], m_norm[FRAC_W-1:0]};
	end

endmodule

/* hw/node_pkg.sv */
package node_pkg;

	import float_pkg::*;

	localparam int NUM_INPUTS = 10;

	// Input set to result strobe, in clock cycles.
	localparam int NODE_LATENCY = 6;

	// ############################################################
	// Fixed weights, mixed signs
	// ############################################################
	localparam float_t NODE_WEIGHTS [NUM_INPUTS] = '{
		32'hbea8_3d82,                    // About -0.3286.
		32'h3f00_0000,                    // 0.5
		32'h3f40_0000,                    // 0.75
		32'hbe80_0000,                    // -0.25
		32'h3fa0_0000,                    // 1.25
		32'hbf20_0000,                    // -0.625
		32'h3ec0_0000,                    // 0.375
		32'hbfc0_0000,                    // -1.5
		32'h3f60_0000,                    // 0.875
		32'h3e00_0000                     // 0.125
	};

endpackage

/* hw/float_pkg.sv */
package float_pkg;

	// ############################################################
	// Field widths and limits
	// ############################################################
	localparam int FRAC_W = 23;
	localparam int EXP_BIAS = 127;
	localparam int EXP_MAX_FINITE = 254;

	// Word layout is sign, exponent, fraction.
	typedef logic [31:0] float_t;
	typedef logic [7:0] exp_t;
	typedef logic [FRAC_W:0] mant_t;      // Hidden one on top.

	// Largest finite magnitude, sign bit cleared.
	localparam float_t FLOAT_MAX_MAG = 32'h7f7f_ffff;

endpackage
